/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

    localparam int IMG_DIM     = 8;
    localparam int OUT_DIM     = IMG_DIM - 2;          // valid outputs only.
    localparam int NUM_RESULTS = OUT_DIM * OUT_DIM;
    localparam int KERNEL_TAPS = 9;
    localparam int AXI_ADDR_W  = 12;
    localparam int AXI_DATA_W  = 32;

    // register map.
    localparam logic [AXI_ADDR_W-1:0] ADDR_IMAGE  = 12'h000;   // col*2 + half.
    localparam logic [AXI_ADDR_W-1:0] ADDR_KERNEL = 12'h040;   // nine weights.
    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL   = 12'h080;   // bit 0 starts.
    localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 12'h084;   // busy and done.
    localparam logic [AXI_ADDR_W-1:0] ADDR_RESULT = 12'h100;

    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

    typedef logic [7:0]                   pixel_t;
    typedef logic signed [7:0]            weight_t;
    typedef logic signed [19:0]           result_t;
    typedef pixel_t [IMG_DIM-1:0]         column_t;     // row 0 in low byte.
    typedef pixel_t [KERNEL_TAPS-1:0]     window_t;     // raster order from top-left.
    typedef weight_t [KERNEL_TAPS-1:0]    kernel_t;
    typedef logic [$clog2(IMG_DIM)-1:0]   col_addr_t;
    typedef logic [$clog2(NUM_RESULTS)-1:0] res_addr_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
    } axi_r_t;

endpackage

`default_nettype wire

/* pixel_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_mem #(
    parameter type payload_t = logic [7:0],
    parameter type addr_t    = logic [2:0]
) (
    input wire           clk,
    input wire           wr_en,
    input wire addr_t    wr_addr,
    input wire payload_t wr_data,
    input wire addr_t    rd_addr,
    output payload_t     rd_data
);

    payload_t mem [2**$bits(addr_t)];   // depth follows the address type.

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];          // one cycle read latency.
    end

endmodule

`default_nettype wire

/* conv_csr.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_csr (
    input wire                        clk,
    input wire                        rst,
    input wire conv_pkg::axi_aw_t     aw,
    input wire                        aw_valid,
    output logic                      aw_ready,
    input wire conv_pkg::axi_w_t      w,
    input wire                        w_valid,
    output logic                      w_ready,
    output conv_pkg::axi_b_t          b,
    output logic                      b_valid,
    input wire                        b_ready,
    input wire conv_pkg::axi_ar_t     ar,
    input wire                        ar_valid,
    output logic                      ar_ready,
    output conv_pkg::axi_r_t          r,
    output logic                      r_valid,
    input wire                        r_ready,
    output logic                      img_wr_en,
    output conv_pkg::col_addr_t       img_wr_addr,
    output conv_pkg::column_t         img_wr_data,
    output conv_pkg::res_addr_t       res_rd_addr,
    input wire conv_pkg::result_t     res_rd_data,
    output conv_pkg::kernel_t         kernel,
    output logic                      start,
    input wire                        finished
);
    import conv_pkg::*;

    logic        wr_fire, rd_fire;
    logic        w_img, w_ker, w_ctrl, go;
    logic        r_ker, r_ctrl, r_stat, r_res;
    logic        res_pend;                   // waiting on result memory.
    logic        busy, done;
    logic [31:0] img_low;                    // rows 0 to 3 of the column.
    logic [31:0] rd_word;

    assign wr_fire = aw_ready && aw_valid && w_valid;
    assign rd_fire = ar_ready && ar_valid;
    assign w_ready = aw_ready;               // aw and w taken together.

    assign w_img  = aw.addr[11:6] == ADDR_IMAGE[11:6];
    assign w_ker  = aw.addr[11:6] == ADDR_KERNEL[11:6] && aw.addr[5:2] < KERNEL_TAPS;
    assign w_ctrl = aw.addr[11:2] == ADDR_CTRL[11:2];
    assign go     = wr_fire && w_ctrl && w.strb[0] && w.data[0] && !busy;

    assign img_wr_en   = wr_fire && w_img && aw.addr[2];   // high half commits.
    assign img_wr_addr = aw.addr[5:3];
    assign img_wr_data = {w.data, img_low};

    assign r_res  = ar.addr[11:8] == ADDR_RESULT[11:8] && ar.addr[7:2] < NUM_RESULTS;
    assign r_ker  = ar.addr[11:6] == ADDR_KERNEL[11:6] && ar.addr[5:2] < KERNEL_TAPS;
    assign r_ctrl = ar.addr[11:2] == ADDR_CTRL[11:2];
    assign r_stat = ar.addr[11:2] == ADDR_STATUS[11:2];
    assign res_rd_addr = ar.addr[7:2];

    always_comb
    begin
        rd_word = '0;
        if (r_ker)
        begin
            rd_word = {{24{kernel[ar.addr[5:2]][7]}}, kernel[ar.addr[5:2]]};
        end
        else if (r_stat)
        begin
            rd_word = {30'd0, done, busy};
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire && w_img && !aw.addr[2])
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (w.strb[i])
                begin
                    img_low[i*8 +: 8] <= w.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            aw_ready <= 1'b0;
            b_valid  <= 1'b0;
            b        <= '0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r        <= '0;
            res_pend <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            start    <= 1'b0;
            kernel   <= '0;
        end
        else
        begin
            aw_ready <= aw_valid && w_valid && !aw_ready && !b_valid;
            if (wr_fire)
            begin
                b_valid <= 1'b1;
                b.resp  <= (w_img || w_ker || w_ctrl) ? AXI_OKAY : AXI_SLVERR;
            end
            else if (b_ready)
            begin
                b_valid <= 1'b0;
            end
            if (wr_fire && w_ker && w.strb[0])
            begin
                kernel[aw.addr[5:2]] <= w.data[7:0];
            end

            ar_ready <= ar_valid && !ar_ready && !res_pend && !r_valid;
            res_pend <= rd_fire && r_res;
            if (rd_fire && !r_res)
            begin
                r_valid <= 1'b1;
                r.data  <= rd_word;
                r.resp  <= (r_ker || r_ctrl || r_stat) ? AXI_OKAY : AXI_SLVERR;
            end
            else if (res_pend)
            begin
                r_valid <= 1'b1;
                r.data  <= {{12{res_rd_data[19]}}, res_rd_data};   // sign extend.
                r.resp  <= AXI_OKAY;
            end
            else if (r_ready)
            begin
                r_valid <= 1'b0;
            end

            start <= go;
            if (go)
            begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            else if (finished)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    b_hold: assert property (@(posedge clk) disable iff (!rst)
        b_valid && !b_ready |=> b_valid && $stable(b));

    // a run is only launched from the idle state.
    start_idle: assert property (@(posedge clk) disable iff (!rst)
        start |-> $rose(busy));

endmodule

`default_nettype wire

/* window_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module window_fetch (
    input wire                    clk,
    input wire                    rst,
    input wire                    start,
    output conv_pkg::col_addr_t   col_rd_addr,
    input wire conv_pkg::column_t col_data,
    output conv_pkg::pixel_t      pixel0,
    output conv_pkg::pixel_t      pixel1,
    output conv_pkg::pixel_t      pixel2,
    output conv_pkg::pixel_t      pixel3,
    output conv_pkg::pixel_t      pixel4,
    output conv_pkg::pixel_t      pixel5,
    output conv_pkg::pixel_t      pixel6,
    output conv_pkg::pixel_t      pixel7,
    output conv_pkg::pixel_t      pixel8,
    output logic                  load_full_patch,
    output logic                  window_valid,
    output logic                  finished
);
    import conv_pkg::*;

    typedef enum logic {S_IDLE, S_SCAN} state_t;

    state_t                       state;
    col_addr_t                    col;        // column read this cycle.
    logic [$clog2(OUT_DIM)-1:0]   row;        // top row of the window.
    logic                         rd_active, rd_last;
    logic                         d_valid, d_last, wv_last;
    col_addr_t                    d_col;      // column arriving on col_data.
    logic [$clog2(OUT_DIM)-1:0]   d_row;
    column_t                      hold0, hold1;

    // the start cycle already reads column 0.
    assign rd_active   = state == S_SCAN || start;
    assign rd_last     = rd_active && row == OUT_DIM - 1 && col == col_addr_t'(IMG_DIM - 1);
    assign col_rd_addr = col;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state        <= S_IDLE;
            col          <= '0;
            row          <= '0;
            d_valid      <= 1'b0;
            d_last       <= 1'b0;
            d_col        <= '0;
            d_row        <= '0;
            window_valid <= 1'b0;
            wv_last      <= 1'b0;
            finished     <= 1'b0;
        end
        else
        begin
            if (rd_active)
            begin
                col   <= col + 1'b1;          // wraps to 0 after column 7.
                state <= rd_last ? S_IDLE : S_SCAN;
                if (col == col_addr_t'(IMG_DIM - 1))
                begin
                    row <= rd_last ? '0 : row + 1'b1;
                end
            end
            d_valid      <= rd_active;
            d_last       <= rd_last;
            d_col        <= col;
            d_row        <= row;
            window_valid <= d_valid && d_col >= col_addr_t'(2);
            wv_last      <= d_last;
            finished     <= wv_last;           // last result written now.
        end
    end

    always_ff @(posedge clk)
    begin
        if (d_valid && d_col == col_addr_t'(0))
        begin
            hold0 <= col_data;
        end
        if (d_valid && d_col == col_addr_t'(1))
        begin
            hold1 <= col_data;
        end
    end

    assign load_full_patch = d_valid && d_col == col_addr_t'(2);

    assign pixel0 = hold0[d_row];
    assign pixel1 = hold0[d_row + 3'd1];
    assign pixel2 = hold0[d_row + 3'd2];
    assign pixel3 = hold1[d_row];
    assign pixel4 = hold1[d_row + 3'd1];
    assign pixel5 = hold1[d_row + 3'd2];
    assign pixel6 = col_data[d_row];         // new right column.
    assign pixel7 = col_data[d_row + 3'd1];
    assign pixel8 = col_data[d_row + 3'd2];

    load_in_scan: assert property (@(posedge clk) disable iff (!rst)
        load_full_patch |-> state != S_IDLE);

endmodule

`default_nettype wire

/* image_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module image_reg (
    input wire                   clk,
    input wire                   rst,
    input wire                   load_full_patch,
    input wire conv_pkg::pixel_t pixel0,
    input wire conv_pkg::pixel_t pixel1,
    input wire conv_pkg::pixel_t pixel2,
    input wire conv_pkg::pixel_t pixel3,
    input wire conv_pkg::pixel_t pixel4,
    input wire conv_pkg::pixel_t pixel5,
    input wire conv_pkg::pixel_t pixel6,
    input wire conv_pkg::pixel_t pixel7,
    input wire conv_pkg::pixel_t pixel8,
    output conv_pkg::window_t    window
);
    import conv_pkg::*;

    pixel_t [KERNEL_TAPS-1:0] regs;   // column-major with 0 to 2 the left column.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            regs <= '0;
        end
        else if (load_full_patch)
        begin
            regs <= {pixel8, pixel7, pixel6, pixel5, pixel4, pixel3, pixel2, pixel1, pixel0};
        end
        else
        begin
            regs <= {pixel8, pixel7, pixel6, regs[8:3]};   // shift left one column.
        end
    end

    // raster order out of the column-major registers.
    always_comb
    begin
        for (int rr = 0; rr < 3; rr++)
        begin
            for (int cc = 0; cc < 3; cc++)
            begin
                window[rr*3 + cc] = regs[cc*3 + rr];
            end
        end
    end

endmodule

`default_nettype wire

/* conv_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_mac (
    input wire                    clk,
    input wire                    rst,
    input wire conv_pkg::window_t window,
    input wire conv_pkg::kernel_t kernel,
    input wire                    window_valid,
    input wire                    start,
    output logic                  res_wr_en,
    output conv_pkg::res_addr_t   res_wr_addr,
    output conv_pkg::result_t     res_wr_data
);
    import conv_pkg::*;

    logic signed [16:0] prod [KERNEL_TAPS];   // 9 bit unsigned times 8 bit signed.
    logic               prod_valid;
    res_addr_t          idx;
    result_t            acc;

    always_ff @(posedge clk)
    begin
        if (window_valid)
        begin
            for (int i = 0; i < KERNEL_TAPS; i++)
            begin
                prod[i] <= $signed({1'b0, window[i]}) * $signed(kernel[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            prod_valid <= 1'b0;
            idx        <= '0;
        end
        else
        begin
            prod_valid <= window_valid;
            if (start)
            begin
                idx <= '0;
            end
            else if (prod_valid)
            begin
                idx <= idx + 1'b1;              // raster order of results.
            end
        end
    end

    always_comb
    begin
        acc = '0;
        for (int i = 0; i < KERNEL_TAPS; i++)
        begin
            acc = acc + prod[i];
        end
    end

    assign res_wr_en   = prod_valid;
    assign res_wr_addr = idx;
    assign res_wr_data = acc;

    idx_range: assert property (@(posedge clk) disable iff (!rst)
        res_wr_en |-> res_wr_addr <= NUM_RESULTS - 1);

endmodule

`default_nettype wire

/* conv_top.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_top (
    input wire                    clk,
    input wire                    rst,
    input wire conv_pkg::axi_aw_t aw,
    input wire                    aw_valid,
    output logic                  aw_ready,
    input wire conv_pkg::axi_w_t  w,
    input wire                    w_valid,
    output logic                  w_ready,
    output conv_pkg::axi_b_t      b,
    output logic                  b_valid,
    input wire                    b_ready,
    input wire conv_pkg::axi_ar_t ar,
    input wire                    ar_valid,
    output logic                  ar_ready,
    output conv_pkg::axi_r_t      r,
    output logic                  r_valid,
    input wire                    r_ready
);
    import conv_pkg::*;

    logic      img_wr_en, res_wr_en;
    col_addr_t img_wr_addr, col_rd_addr;
    column_t   img_wr_data, col_data;
    res_addr_t res_rd_addr, res_wr_addr;
    result_t   res_rd_data, res_wr_data;
    kernel_t   kernel;
    window_t   window;
    pixel_t    pixel0, pixel1, pixel2, pixel3, pixel4, pixel5, pixel6, pixel7, pixel8;
    logic      start, finished, load_full_patch, window_valid;

    conv_csr u_csr (.*);

    pixel_mem #(
        .payload_t (column_t),
        .addr_t    (col_addr_t)
    ) u_image_mem (
        .clk     (clk),
        .wr_en   (img_wr_en),
        .wr_addr (img_wr_addr),
        .wr_data (img_wr_data),
        .rd_addr (col_rd_addr),
        .rd_data (col_data)
    );

    window_fetch u_fetch (.*);

    image_reg u_image_reg (.*);

    conv_mac u_mac (.*);

    pixel_mem #(
        .payload_t (result_t),
        .addr_t    (res_addr_t)
    ) u_result_mem (
        .clk     (clk),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_data),
        .rd_addr (res_rd_addr),
        .rd_data (res_rd_data)
    );

endmodule

`default_nettype wire

/* tb_conv.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_conv;
    import conv_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    logic    clk;
    logic    rst;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    pixel_t  img [IMG_DIM][IMG_DIM];        // [row][col].
    weight_t kern [KERNEL_TAPS];
    result_t exp_res [NUM_RESULTS];
    int      errors;
    int      checks;
    int      cycles;

    conv_top u_conv_top (.*);

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic check_result(input result_t got, input result_t exp, input int idx);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: result %0d is %0d, expected %0d", $time, idx, got, exp);
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: status done/busy %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s response %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    // called and returns 2 ns after a rising edge.
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        aw.addr  = addr;
        w.data   = data;
        w.strb   = 4'hf;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (!(aw_ready && w_ready))
        begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);                      // aw and w taken here.
        #2;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b1;
        while (!b_valid)
        begin
            @(posedge clk);
            #2;
        end
        resp = b.resp;
        @(posedge clk);
        #2;
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        ar.addr  = addr;
        ar_valid = 1'b1;
        while (!ar_ready)
        begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        ar_valid = 1'b0;
        r_ready  = 1'b1;
        while (!r_valid)
        begin
            @(posedge clk);
            #2;
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk);
        #2;
        r_ready = 1'b0;
    endtask

    task automatic write_expect_okay(input logic [11:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp(resp, AXI_OKAY, "write");
    endtask

    task automatic load_image();
        logic [31:0] word;
        for (int c = 0; c < IMG_DIM; c++)
        begin
            for (int h = 0; h < 2; h++)
            begin
                word = {img[h*4+3][c], img[h*4+2][c], img[h*4+1][c], img[h*4][c]};
                write_expect_okay(ADDR_IMAGE + 12'((c*2 + h) * 4), word);   // low half first.
            end
        end
    endtask

    task automatic load_kernel();
        for (int k = 0; k < KERNEL_TAPS; k++)
        begin
            write_expect_okay(ADDR_KERNEL + 12'(k * 4), {24'd0, kern[k]});
        end
    endtask

    task automatic start_run();
        write_expect_okay(ADDR_CTRL, 32'd1);
    endtask

    task automatic wait_done();
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (!data[1])
        begin
            axi_read(ADDR_STATUS, data, resp);
        end
        check_resp(resp, AXI_OKAY, "status read");
        check_status(data[1:0], 2'b10);
    endtask

    task automatic run_and_wait();
        start_run();
        wait_done();
    endtask

    // valid convolution over each window with top-left at (rr, cc).
    task automatic compute_expected();
        int sum;
        for (int rr = 0; rr < OUT_DIM; rr++)
        begin
            for (int cc = 0; cc < OUT_DIM; cc++)
            begin
                sum = 0;
                for (int i = 0; i < 3; i++)
                begin
                    for (int j = 0; j < 3; j++)
                    begin
                        sum += int'(img[rr+i][cc+j]) * int'(kern[i*3 + j]);
                    end
                end
                exp_res[rr*OUT_DIM + cc] = result_t'(sum);
            end
        end
    endtask

    task automatic compare_results();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < NUM_RESULTS; i++)
        begin
            axi_read(ADDR_RESULT + 12'(i * 4), data, resp);
            check_resp(resp, AXI_OKAY, "result read");
            check_result(result_t'(data[19:0]), exp_res[i], i);
            check_data(data, 32'(exp_res[i]), "result word");   // sign-extended word.
        end
    endtask

    task automatic randomize_kernel();
        for (int k = 0; k < KERNEL_TAPS; k++)
        begin
            kern[k] = weight_t'($urandom());
        end
    endtask

    task automatic status_after_reset();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(ADDR_STATUS, data, resp);
        check_resp(resp, AXI_OKAY, "status read");
        check_status(data[1:0], 2'b00);
    endtask

    task automatic identity_on_ramp();
        for (int rr = 0; rr < IMG_DIM; rr++)
        begin
            for (int cc = 0; cc < IMG_DIM; cc++)
            begin
                img[rr][cc] = pixel_t'(rr*IMG_DIM + cc);   // ramp.
            end
        end
        for (int k = 0; k < KERNEL_TAPS; k++)
        begin
            kern[k] = (k == 4) ? 8'sd1 : 8'sd0;
        end
        for (int i = 0; i < NUM_RESULTS; i++)
        begin
            exp_res[i] = result_t'(img[i/OUT_DIM + 1][i%OUT_DIM + 1]);   // centre pixel.
        end
        load_image();
        load_kernel();
        run_and_wait();
        compare_results();
    endtask

    task automatic random_image_and_kernel();
        for (int rr = 0; rr < IMG_DIM; rr++)
        begin
            for (int cc = 0; cc < IMG_DIM; cc++)
            begin
                img[rr][cc] = pixel_t'($urandom());
            end
        end
        randomize_kernel();
        kern[0] = -8'sd128;                  // force a large negative tap.
        compute_expected();
        load_image();
        load_kernel();
        run_and_wait();
        compare_results();
    endtask

    task automatic kernel_swap_rerun();
        logic [31:0] data;
        logic [1:0]  resp;
        randomize_kernel();
        compute_expected();
        load_kernel();
        start_run();
        axi_read(ADDR_STATUS, data, resp);
        check_resp(resp, AXI_OKAY, "status read");
        check_status(data[1:0], 2'b01);      // busy set and done cleared.
        wait_done();
        compare_results();
    endtask

    task automatic ignore_start_while_busy();
        randomize_kernel();
        compute_expected();
        load_kernel();
        start_run();
        start_run();                         // lands mid-run.
        wait_done();
        compare_results();
    endtask

    task automatic unmapped_access();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(12'h0c0, 32'hdead_beef, resp);
        check_resp(resp, AXI_SLVERR, "unmapped write");
        axi_write(ADDR_RESULT, 32'h1234_5678, resp);
        check_resp(resp, AXI_SLVERR, "result write");
        axi_read(12'h0c0, data, resp);
        check_resp(resp, AXI_SLVERR, "unmapped read");
        check_data(data, 32'd0, "unmapped read");
        axi_read(ADDR_RESULT + 12'(NUM_RESULTS * 4), data, resp);
        check_resp(resp, AXI_SLVERR, "read past results");
        check_data(data, 32'd0, "read past results");
        axi_read(12'hffc, data, resp);
        check_resp(resp, AXI_SLVERR, "top address read");
        check_data(data, 32'd0, "top address read");
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(56379));
        errors   = 0;
        checks   = 0;
        rst      = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;
        status_after_reset();
        identity_on_ramp();
        random_image_and_kernel();
        kernel_swap_rerun();
        ignore_start_while_busy();
        unmapped_access();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog.
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d clock cycles, errors so far: %0d",
                 TIMEOUT_CYCLES, errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
conv_pkg.sv
pixel_mem.sv
conv_csr.sv
window_fetch.sv
image_reg.sv
conv_mac.sv
conv_top.sv
tb_conv.sv
